// ==== flist.f ====
+incdir+src
src/sb_pkg.sv
src/sb_config_regs.sv
src/sb_row_shifter.sv
src/sb_block_tracker.sv
src/sb_shift_buffer.sv
dv/tb_sb_shift_buffer.sv

// ==== Bender.yml ====
package:
  name: sb_shift_buffer

sources:
  - include_dirs:
      - src
    files:
      - src/sb_pkg.sv
      - src/sb_config_regs.sv
      - src/sb_row_shifter.sv
      - src/sb_block_tracker.sv
      - src/sb_shift_buffer.sv
  - target: test
    include_dirs:
      - src
    files:
      - dv/tb_sb_shift_buffer.sv

// ==== dv/tb_sb_shift_buffer.sv ====
`default_nettype none

`include "sb_defines.svh"

module tb_sb_shift_buffer;

    // one test run: config, row count, share of stalled out_ready cycles
    typedef struct packed {
        logic [7:0] kh_1;
        logic [7:0] kw_1;
        logic [7:0] cin_1;
        logic [7:0] cols_1;
        logic [7:0] rows;
        logic [7:0] stall_pct;
    } entry_t;

    localparam int N_ENTRIES = 6;
    localparam int W         = `SB_DATA_WIDTH;
    localparam int COLS_MOD  = 1 << `SB_COLS_WIDTH;

    logic                       aclk;
    logic                       rst_n;
    logic                       start;
    sb_pkg::kh_t                kernel_h_1_in;
    sb_pkg::kw_t                kernel_w_1_in;
    sb_pkg::cin_t               cin_1_in;
    sb_pkg::cols_t              cols_1_in;
    logic                       in_valid;
    sb_pkg::row_t               in_data;
    logic                       in_ready;
    logic                       out_valid;
    logic                       out_ready;
    sb_pkg::beat_t              out_data;
    logic                       out_last;
    logic [`SB_TUSER_WIDTH-1:0] out_user;
    sb_pkg::kh_t                kernel_h_1_out;
    sb_pkg::kw_t                kernel_w_1_out;

    entry_t tbl [N_ENTRIES];
    integer seed;
    int     errors;
    int     checks;
    logic   timed_out;

    // model counters live across runs, start does not clear them
    int   m_cin;
    int   m_cols;
    logic m_flag;

    sb_pkg::beat_t              exp_data_q [$];
    logic                       exp_last_q [$];
    logic [`SB_TUSER_WIDTH-1:0] exp_user_q [$];

    sb_shift_buffer i_dut (
        .aclk           (aclk),
        .rst_n          (rst_n),
        .start          (start),
        .kernel_h_1_in  (kernel_h_1_in),
        .kernel_w_1_in  (kernel_w_1_in),
        .cin_1_in       (cin_1_in),
        .cols_1_in      (cols_1_in),
        .in_valid       (in_valid),
        .in_data        (in_data),
        .in_ready       (in_ready),
        .out_valid      (out_valid),
        .out_ready      (out_ready),
        .out_data       (out_data),
        .out_last       (out_last),
        .out_user       (out_user),
        .kernel_h_1_out (kernel_h_1_out),
        .kernel_w_1_out (kernel_w_1_out)
    );

    always #4 aclk = ~aclk;

    task automatic check_value(input string name, input logic [63:0] exp,
                               input logic [63:0] got);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("Mismatch at %0t: %s expected %h got %h", $time, name, exp, got);
        end
    endtask

    // expected beats of one accepted row, then step the group counters
    task automatic predict_row(input sb_pkg::row_t row, input entry_t e);
        sb_pkg::row_t               shifted;
        logic [`SB_TUSER_WIDTH-1:0] user;
        int                         k;
        int                         cols_k2;
        user = '0;
        user[sb_pkg::TUSER_IS_1X1]       = (e.kh_1 == 0);
        user[sb_pkg::TUSER_IS_COLS_1_K2] = m_flag;   // flag of the current group
        for (k = 0; k <= e.kh_1; k++) begin
            shifted = row >> (k * W);                 // window k starts at word k
            exp_data_q.push_back(shifted[`SB_CONV_UNITS*W-1:0]);
            exp_last_q.push_back((k == e.kh_1) && (m_cin == e.cin_1));
            exp_user_q.push_back(user);
        end
        if (m_cin == e.cin_1) begin
            m_cin   = 0;
            m_cols  = (m_cols == e.cols_1) ? 0 : m_cols + 1;
            // cols_1 - kw_1/2 - 1, wrapped to counter width
            cols_k2 = (int'(e.cols_1) + COLS_MOD - int'(e.kw_1) / 2 - 1) % COLS_MOD;
            m_flag  = (m_cols == cols_k2);
        end else begin
            m_cin++;
        end
    endtask

    task automatic run_entry(input entry_t e, input int idx, output logic to);
        int                         rows_sent;
        int                         beats_got;
        int                         beats_exp;
        int                         cycles;
        int                         limit;
        int                         err_before;
        int                         i;
        logic                       pending;
        logic                       held;
        sb_pkg::row_t               row;
        sb_pkg::beat_t              held_data;
        logic                       held_last;
        logic [`SB_TUSER_WIDTH-1:0] held_user;
        err_before = errors;
        beats_exp  = e.rows * (e.kh_1 + 1);
        limit      = beats_exp * 20 + 100;
        rows_sent  = 0;
        beats_got  = 0;
        cycles     = 0;
        pending    = 1'b0;
        held       = 1'b0;
        row        = '0;
        to         = 1'b0;
        @(posedge aclk);
        #1;
        start         = 1'b1;                      // one cycle strobe
        kernel_h_1_in = sb_pkg::kh_t'(e.kh_1);
        kernel_w_1_in = sb_pkg::kw_t'(e.kw_1);
        cin_1_in      = sb_pkg::cin_t'(e.cin_1);
        cols_1_in     = sb_pkg::cols_t'(e.cols_1);
        @(posedge aclk);
        #1;
        start = 1'b0;
        @(negedge aclk);
        check_value("kernel_h_1_out", e.kh_1, kernel_h_1_out);
        check_value("kernel_w_1_out", e.kw_1, kernel_w_1_out);
        while (beats_got < beats_exp && cycles <= limit) begin
            @(posedge aclk);
            #1;
            cycles++;
            if (!pending && rows_sent < e.rows) begin
                for (i = 0; i < `SB_IN_WORDS; i++) begin
                    row[i*W +: W] = $random(seed);
                end
                pending = 1'b1;
            end
            in_valid  = pending;                   // row held until taken
            in_data   = pending ? row : '0;
            out_ready = ($unsigned($random(seed)) % 100) >= e.stall_pct;
            @(negedge aclk);                       // everything settled here
            if (held) begin
                checks++;
                if (!out_valid) begin
                    errors++;
                    $display("ERROR: out_valid dropped at %0t while a beat was stalled", $time);
                end
                check_value("out_data held", held_data, out_data);
                check_value("out_last held", held_last, out_last);
                check_value("out_user held", held_user, out_user);
            end
            held      = out_valid && !out_ready;
            held_data = out_data;
            held_last = out_last;
            held_user = out_user;
            if (in_valid && in_ready) begin
                predict_row(row, e);
                pending = 1'b0;
                rows_sent++;
            end
            if (out_valid && out_ready) begin
                beats_got++;
                if (exp_data_q.size() == 0) begin
                    errors++;
                    $display("ERROR: beat at %0t with no row left to send it", $time);
                end else begin
                    check_value("out_data", exp_data_q.pop_front(), out_data);
                    check_value("out_last", exp_last_q.pop_front(), out_last);
                    check_value("out_user", exp_user_q.pop_front(), out_user);
                end
            end
        end
        if (beats_got < beats_exp) begin
            to = 1'b1;
            $display("ERROR: entry %0d timed out after %0d of %0d beats", idx, beats_got,
                     beats_exp);
        end else begin
            @(posedge aclk);
            #1;
            in_valid  = 1'b0;
            out_ready = 1'b1;
            @(negedge aclk);
            check_value("out_valid after run", 1'b0, out_valid);  // no extra beat
        end
        $display("entry %0d kh_1=%0d kw_1=%0d cin_1=%0d cols_1=%0d stall=%0d: %0d beats, %0d errors",
                 idx, e.kh_1, e.kw_1, e.cin_1, e.cols_1, e.stall_pct, beats_got,
                 errors - err_before);
    endtask

    initial begin
        seed          = 32'hf023afb8;
        errors        = 0;
        checks        = 0;
        timed_out     = 1'b0;
        m_cin         = 0;
        m_cols        = 0;
        m_flag        = 1'b0;
        aclk          = 1'b0;
        rst_n         = 1'b0;
        start         = 1'b0;
        kernel_h_1_in = '0;
        kernel_w_1_in = '0;
        cin_1_in      = '0;
        cols_1_in     = '0;
        in_valid      = 1'b0;
        in_data       = '0;
        out_ready     = 1'b0;
        // kh_1, kw_1, cin_1, cols_1, rows, stall %
        tbl[0] = {8'd2, 8'd2, 8'd1, 8'd3, 8'd16, 8'd0};
        tbl[1] = {8'd0, 8'd0, 8'd2, 8'd2, 8'd18, 8'd0};
        tbl[2] = {8'd2, 8'd2, 8'd0, 8'd4, 8'd20, 8'd40};
        tbl[3] = {8'd1, 8'd1, 8'd3, 8'd1, 8'd16, 8'd50};
        tbl[4] = {8'd0, 8'd2, 8'd1, 8'd2, 8'd12, 8'd30};
        tbl[5] = {8'd2, 8'd0, 8'd1, 8'd2, 8'd12, 8'd60};
        repeat (3) @(posedge aclk);
        #1;
        rst_n = 1'b1;
        @(negedge aclk);
        check_value("in_ready after reset", 1'b1, in_ready);
        check_value("out_valid after reset", 1'b0, out_valid);
        for (int n = 0; n < N_ENTRIES; n++) begin
            if (!timed_out) begin
                run_entry(tbl[n], n, timed_out);
            end
        end
        $display("checks %0d, errors %0d", checks, errors);
        if (timed_out || errors != 0) begin
            $display("TESTBENCH FAILED");
        end else begin
            $display("TESTBENCH PASSED");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== src/sb_shift_buffer.sv ====
`default_nettype none

`include "sb_defines.svh"

// conv input shift buffer, padded rows in, kernel_h shifted windows out
module sb_shift_buffer (
    input  wire                aclk,
    input  wire                rst_n,
    input  wire                start,

    input  wire sb_pkg::kh_t   kernel_h_1_in,
    input  wire sb_pkg::kw_t   kernel_w_1_in,
    input  wire sb_pkg::cin_t  cin_1_in,
    input  wire sb_pkg::cols_t cols_1_in,

    input  wire                in_valid,
    input  wire sb_pkg::row_t  in_data,
    output logic               in_ready,

    output logic               out_valid,
    input  wire                out_ready,
    output sb_pkg::beat_t      out_data,
    output logic               out_last,
    output logic [`SB_TUSER_WIDTH-1:0] out_user,

    output sb_pkg::kh_t        kernel_h_1_out,  // captured sizes for downstream
    output sb_pkg::kw_t        kernel_w_1_out
);

    sb_pkg::kh_t   kernel_h_1;
    sb_pkg::kw_t   kernel_w_1;
    sb_pkg::cin_t  cin_1;
    sb_pkg::cols_t cols_1;

    logic is_1x1;
    logic is_cols_1_k2;
    logic last_shift;
    logic row_done;

    sb_config_regs i_config (
        .aclk          (aclk),
        .rst_n         (rst_n),
        .start         (start),
        .kernel_h_1_in (kernel_h_1_in),
        .kernel_w_1_in (kernel_w_1_in),
        .cin_1_in      (cin_1_in),
        .cols_1_in     (cols_1_in),
        .kernel_h_1    (kernel_h_1),
        .kernel_w_1    (kernel_w_1),
        .cin_1         (cin_1),
        .cols_1        (cols_1),
        .is_1x1        (is_1x1)
    );

    sb_row_shifter i_shifter (
        .aclk       (aclk),
        .rst_n      (rst_n),
        .kernel_h_1 (kernel_h_1),
        .in_valid   (in_valid),
        .in_data    (in_data),
        .in_ready   (in_ready),
        .out_ready  (out_ready),
        .out_valid  (out_valid),
        .out_data   (out_data),
        .last_shift (last_shift),
        .row_done   (row_done)
    );

    sb_block_tracker i_tracker (
        .aclk         (aclk),
        .rst_n        (rst_n),
        .cin_1        (cin_1),
        .cols_1       (cols_1),
        .kernel_w_1   (kernel_w_1),
        .last_shift   (last_shift),
        .row_done     (row_done),
        .out_last     (out_last),
        .is_cols_1_k2 (is_cols_1_k2)
    );

    // sideband: run flag and block flag
    assign out_user[sb_pkg::TUSER_IS_1X1]       = is_1x1;
    assign out_user[sb_pkg::TUSER_IS_COLS_1_K2] = is_cols_1_k2;

    assign kernel_h_1_out = kernel_h_1;
    assign kernel_w_1_out = kernel_w_1;

endmodule

`default_nettype wire

// ==== src/sb_block_tracker.sv ====
`default_nettype none

`include "sb_defines.svh"

// counts rows into channel groups and groups into column blocks
module sb_block_tracker (
    input  wire                aclk,
    input  wire                rst_n,
    input  wire sb_pkg::cin_t  cin_1,
    input  wire sb_pkg::cols_t cols_1,
    input  wire sb_pkg::kw_t   kernel_w_1,

    input  wire                last_shift,     // final window on the output
    input  wire                row_done,       // final window transferred

    output logic               out_last,       // end of channel group
    output logic               is_cols_1_k2    // flagged column block
);

    sb_pkg::cin_t  cin_count;       // rows seen in the current group
    sb_pkg::cols_t cols_count;      // groups seen in the current block
    sb_pkg::cols_t cols_next;
    sb_pkg::cols_t kw_half;
    sb_pkg::cols_t cols_k2;         // column index that gets the flag

    logic group_end;

    assign group_end = (cin_count == cin_1);

    // last beat of last row in the group
    assign out_last = last_shift && group_end;

    // wraps at cols_1
    assign cols_next = (cols_count == cols_1) ? '0 : cols_count + 1'b1;

    assign kw_half = sb_pkg::cols_t'(kernel_w_1 >> 1);
    assign cols_k2 = cols_1 - kw_half - sb_pkg::cols_t'(1);

    always_ff @(posedge aclk) begin
        if (!rst_n) begin
            cin_count    <= '0;
            cols_count   <= '0;
            is_cols_1_k2 <= 1'b0;
        end else if (row_done) begin
            if (group_end) begin
                cin_count    <= '0;
                cols_count   <= cols_next;
                // flag follows the group that starts now
                is_cols_1_k2 <= (cols_next == cols_k2);
            end else begin
                cin_count <= cin_count + 1'b1;
            end
        end
    end

endmodule

`default_nettype wire

// ==== src/sb_row_shifter.sv ====
`default_nettype none

`include "sb_defines.svh"

// holds one padded row and walks it down one word per output beat
module sb_row_shifter (
    input  wire               aclk,
    input  wire               rst_n,
    input  wire sb_pkg::kh_t  kernel_h_1,     // beats per row minus one

    input  wire               in_valid,
    input  wire sb_pkg::row_t in_data,
    output logic              in_ready,

    input  wire               out_ready,
    output logic              out_valid,
    output sb_pkg::beat_t     out_data,

    output logic              last_shift,     // current beat is the row's final window
    output logic              row_done        // final window handed over this cycle
);

    localparam int W = `SB_DATA_WIDTH;
    localparam int N = `SB_IN_WORDS;

    sb_pkg::word_t data_q [N];      // row words, index 0 is the lowest
    sb_pkg::kh_t   shift_idx;       // window number of the beat on out_data

    logic in_xfer;
    logic beat_xfer;

    assign beat_xfer = out_valid && out_ready;
    assign last_shift = out_valid && (shift_idx == kernel_h_1);
    assign row_done = beat_xfer && last_shift;

    // free when empty, or when the last window leaves this cycle
    assign in_ready = !out_valid || (last_shift && out_ready);
    assign in_xfer  = in_valid && in_ready;

    // handshake state
    always_ff @(posedge aclk) begin
        if (!rst_n) begin
            out_valid <= 1'b0;
            shift_idx <= '0;
        end else if (in_xfer) begin
            out_valid <= 1'b1;          // new row, first window next cycle
            shift_idx <= '0;
        end else if (row_done) begin
            out_valid <= 1'b0;          // nothing queued behind it
            shift_idx <= '0;
        end else if (beat_xfer) begin
            shift_idx <= shift_idx + 1'b1;
        end
    end

    // word registers
    always_ff @(posedge aclk) begin
        if (!rst_n) begin
            for (int i = 0; i < N; i++) begin
                data_q[i] <= '0;
            end
        end else if (in_xfer) begin
            for (int i = 0; i < N; i++) begin
                data_q[i] <= in_data[i*W +: W];  // unpack row
            end
        end else if (beat_xfer) begin
            // step down by one word, top word just holds
            for (int i = 0; i < N - 1; i++) begin
                data_q[i] <= data_q[i+1];
            end
        end
    end

    // lowest words form the window
    always_comb begin
        for (int i = 0; i < `SB_CONV_UNITS; i++) begin
            out_data[i*W +: W] = data_q[i];
        end
    end

endmodule

`default_nettype wire

// ==== src/sb_config_regs.sv ====
`default_nettype none

`include "sb_defines.svh"

// run configuration, sampled on start and held until the next start
module sb_config_regs (
    input  wire              aclk,
    input  wire              rst_n,
    input  wire              start,          // single cycle strobe

    input  wire sb_pkg::kh_t   kernel_h_1_in,
    input  wire sb_pkg::kw_t   kernel_w_1_in,
    input  wire sb_pkg::cin_t  cin_1_in,
    input  wire sb_pkg::cols_t cols_1_in,

    output sb_pkg::kh_t      kernel_h_1,
    output sb_pkg::kw_t      kernel_w_1,
    output sb_pkg::cin_t     cin_1,
    output sb_pkg::cols_t    cols_1,
    output logic             is_1x1          // kernel height of one
);

    logic is_1x1_in;

    // decided once at capture, consumers only read the flag
    assign is_1x1_in = (kernel_h_1_in == '0);

    always_ff @(posedge aclk) begin
        if (!rst_n) begin
            kernel_h_1 <= '0;           // zero config, a 1x1 kernel
            kernel_w_1 <= '0;
            cin_1      <= '0;
            cols_1     <= '0;
            is_1x1     <= 1'b0;         // flag stays low until a real start
        end else if (start) begin
            kernel_h_1 <= kernel_h_1_in;
            kernel_w_1 <= kernel_w_1_in;
            cin_1      <= cin_1_in;
            cols_1     <= cols_1_in;
            is_1x1     <= is_1x1_in;
        end
    end

endmodule

`default_nettype wire

// ==== src/sb_pkg.sv ====
`default_nettype none

`include "sb_defines.svh"

package sb_pkg;

    // one pixel word
    typedef logic [`SB_DATA_WIDTH-1:0] word_t;

    // flattened padded row, word 0 at the low end
    typedef logic [`SB_IN_WORDS*`SB_DATA_WIDTH-1:0] row_t;

    // flattened output beat, one word per conv unit
    typedef logic [`SB_CONV_UNITS*`SB_DATA_WIDTH-1:0] beat_t;

    typedef logic [`SB_KH_WIDTH-1:0]   kh_t;    // kernel_h - 1, also shift index
    typedef logic [`SB_KW_WIDTH-1:0]   kw_t;    // kernel_w - 1
    typedef logic [`SB_CIN_WIDTH-1:0]  cin_t;   // channel count
    typedef logic [`SB_COLS_WIDTH-1:0] cols_t;  // column count

    // out_user bit positions
    localparam int TUSER_IS_1X1       = 0;
    localparam int TUSER_IS_COLS_1_K2 = 1;

endpackage

`default_nettype wire

// ==== src/sb_defines.svh ====
`ifndef SB_DEFINES_SVH
`define SB_DEFINES_SVH

// word size of the pixel stream
`define SB_DATA_WIDTH   8

// parallel conv units, one word each per output beat
`define SB_CONV_UNITS   4

// largest kernel the buffer can serve
`define SB_KERNEL_H_MAX 3
`define SB_KERNEL_W_MAX 3

// padded row: conv units plus the extra words needed by the tallest kernel
`define SB_IN_WORDS     (`SB_CONV_UNITS + `SB_KERNEL_H_MAX - 1)

// kernel size minus one, also the shift index range
`define SB_KH_WIDTH     $clog2(`SB_KERNEL_H_MAX)
`define SB_KW_WIDTH     $clog2(`SB_KERNEL_W_MAX)

// channel and column counters
`define SB_CIN_WIDTH    4
`define SB_COLS_WIDTH   4

// sideband bits on the output stream
`define SB_TUSER_WIDTH  2

`endif
